//--- ip_arb_mux.f
+incdir+include
hw/ip_arb_mux_pkg.sv
hw/rr_arbiter.sv
hw/ip_frame_ctrl.sv
hw/ip_payload_skid.sv
hw/ip_arb_mux.sv
dv/tb_clk_gen.sv
dv/ip_arb_mux_chk.sv
dv/ip_arb_mux_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ip_arb_mux testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert \
    -f ip_arb_mux.f \
    --top-module ip_arb_mux_tb \
    -Mdir "$OBJ"
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$OBJ/Vip_arb_mux_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- dv/ip_arb_mux_tb.sv
`timescale 1ns/1ns

`include "ip_arb_mux_settings.svh"

module ip_arb_mux_tb import ip_arb_mux_pkg::*; ();

    localparam int NPORTS     = `IP_ARB_PORTS;
    localparam int ROUNDS     = 3;
    localparam int MAX_BEATS  = 8;
    localparam int TOT_FRAMES = NPORTS + 3 * ROUNDS * NPORTS;
    localparam int LIMIT_NS   = TOT_FRAMES * MAX_BEATS * 20 * 10 + 200;

    logic                         clk;
    logic                         rst;
    port_mask_t                   s_hdr_valid;
    port_mask_t                   s_hdr_ready;
    ip_hdr_t [`IP_ARB_PORTS-1:0]  s_hdr;
    port_mask_t                   s_pay_valid;
    port_mask_t                   s_pay_ready;
    ip_beat_t [`IP_ARB_PORTS-1:0] s_pay;
    logic                         m_hdr_valid;
    logic                         m_hdr_ready;
    ip_hdr_t                      m_hdr;
    logic                         m_pay_valid;
    logic                         m_pay_ready;
    ip_beat_t                     m_pay;

    integer     seed;
    int         errors;
    int         frames_done;
    int         rr_next;
    logic       pay_bp;
    logic       hdr_bp;
    int         seq_next [NPORTS];
    int         exp_seq [NPORTS];
    logic [7:0] sent_q [NPORTS][$];
    ip_hdr_t    hdr_q [$];
    ip_beat_t   beat_q [$];

    tb_clk_gen clk_gen_i (
        .clk(clk),
        .rst(rst)
    );

    ip_arb_mux ip_arb_mux_i (.*);

    function automatic int beat_count(input int src, input int seq);
        return 1 + ((src * 3 + seq * 5) % MAX_BEATS);
    endfunction

    // source and sequence travel in the source address
    function automatic ip_hdr_t ref_header(input int src, input int seq);
        ip_hdr_t h;
        h.eth_dest_mac    = {40'h02_00_00_00_00, 8'(src)};
        h.eth_src_mac     = {32'h0a_bc_de_00, 8'(seq), 8'(src)};
        h.eth_type        = 16'h0800;
        h.version         = 4'd4;
        h.ihl             = 4'd5;
        h.dscp            = 6'(seq);
        h.ecn             = 2'(src);
        h.length          = 16'(beat_count(src, seq));
        h.identification  = 16'(src * 256 + seq);
        h.flags           = 3'b010;
        h.fragment_offset = 13'(seq * 7);
        h.ttl             = 8'd64;
        h.protocol        = 8'd17;
        h.header_checksum = 16'hbeef ^ 16'(seq);
        h.source_ip       = {8'd10, 8'd0, 8'(src), 8'(seq)};
        h.dest_ip         = {8'd192, 8'd168, 8'(seq), 8'(src)};
        return h;
    endfunction

    function automatic ip_beat_t ref_beat(input int src, input int seq, input int idx,
                                          input logic [7:0] data);
        ip_beat_t b;
        b.data = data;
        b.last = (idx == beat_count(src, seq) - 1);
        b.user = 1'((src + seq + idx) & 1);
        return b;
    endfunction

    // header first then the payload beats of one source
    task automatic run_source(input int src, input int count);
        int         seq;
        int         len;
        logic [7:0] bytes [$];
        @(posedge clk);
        #1;
        for (int f = 0; f < count; f++) begin
            seq = seq_next[src];
            seq_next[src] = seq + 1;
            len = beat_count(src, seq);
            bytes.delete();
            for (int k = 0; k < len; k++) begin
                bytes.push_back(8'($random(seed)));
                sent_q[src].push_back(bytes[k]);
            end
            s_hdr[src] = ref_header(src, seq);
            s_hdr_valid[src] = 1'b1;
            do @(negedge clk); while (!s_hdr_ready[src]);
            @(posedge clk);
            #1 s_hdr_valid[src] = 1'b0;
            for (int k = 0; k < len; k++) begin
                s_pay[src] = ref_beat(src, seq, k, bytes[k]);
                s_pay_valid[src] = 1'b1;
                do @(negedge clk); while (!s_pay_ready[src]);
                @(posedge clk);
                #1;
            end
            s_pay_valid[src] = 1'b0;
        end
    endtask

    task automatic check_idle(input string when);
        if (m_hdr_valid !== 1'b0 || m_pay_valid !== 1'b0 ||
            s_hdr_ready !== '0 || s_pay_ready !== '0) begin
            $display("Error at %0t: outputs not low %s", $time, when);
            errors++;
        end
    endtask

    task automatic wait_frames(input int target);
        while (frames_done < target) @(negedge clk);
    endtask

    initial begin
        int         src;
        int         seq;
        ip_hdr_t    h;
        ip_hdr_t    eh;
        ip_beat_t   b;
        ip_beat_t   eb;
        logic [7:0] d;
        int         stretch;

        seed        = 32'h5308_510d;
        errors      = 0;
        frames_done = 0;
        rr_next     = 0;
        pay_bp      = 1'b0;
        hdr_bp      = 1'b0;
        s_hdr_valid = '0;
        s_hdr       = '0;
        s_pay_valid = '0;
        s_pay       = '0;
        m_hdr_ready = 1'b1;
        m_pay_ready = 1'b1;
        for (int i = 0; i < NPORTS; i++) begin
            seq_next[i] = 0;
            exp_seq[i]  = 0;
        end

        @(posedge clk);
        while (rst) begin
            @(negedge clk);
            if (rst) begin
                check_idle("during reset");
            end
        end
        @(negedge clk);
        check_idle("after reset");

        fork
            // output monitor
            forever begin
                @(negedge clk);
                if (m_hdr_valid && m_hdr_ready) hdr_q.push_back(m_hdr);
                if (m_pay_valid && m_pay_ready) beat_q.push_back(m_pay);
            end
            // output ready drivers
            begin
                stretch = 0;
                forever begin
                    @(posedge clk);
                    #1;
                    m_pay_ready = pay_bp ? 1'($random(seed)) : 1'b1;
                    if (!hdr_bp) begin
                        m_hdr_ready = 1'b1;
                    end else if (stretch == 0) begin
                        m_hdr_ready = ~m_hdr_ready;
                        stretch = 1 + ($unsigned($random(seed)) % 8);
                    end else begin
                        stretch--;
                    end
                end
            end
            // compare against the reference
            forever begin
                while (hdr_q.size() == 0) @(negedge clk);
                h = hdr_q.pop_front();
                src = int'(h.source_ip[15:8]);
                seq = int'(h.source_ip[7:0]);
                if (src >= NPORTS) begin
                    $display("Error at %0t: bad source index %0d", $time, src);
                    errors++;
                    src = 0;
                end
                if (src != rr_next) begin
                    $display("Error at %0t: source %0d out of order, expected %0d",
                             $time, src, rr_next);
                    errors++;
                end
                rr_next = (src + 1) % NPORTS;
                if (seq != exp_seq[src]) begin
                    $display("Error at %0t: source %0d sequence %0d, expected %0d",
                             $time, src, seq, exp_seq[src]);
                    errors++;
                end
                eh = ref_header(src, exp_seq[src]);
                if (h != eh) begin
                    $display("Error at %0t: header %h, expected %h", $time, h, eh);
                    errors++;
                end
                for (int k = 0; k < beat_count(src, exp_seq[src]); k++) begin
                    while (beat_q.size() == 0) @(negedge clk);
                    b = beat_q.pop_front();
                    d = 8'h00;
                    if (sent_q[src].size() == 0) begin
                        $display("Error at %0t: beat with nothing sent by source %0d",
                                 $time, src);
                        errors++;
                    end else begin
                        d = sent_q[src].pop_front();
                    end
                    eb = ref_beat(src, exp_seq[src], k, d);
                    if (b != eb) begin
                        $display("Error at %0t: source %0d beat %0d is %h, expected %h",
                                 $time, src, k, b, eb);
                        errors++;
                    end
                end
                exp_seq[src]++;
                frames_done++;
            end
        join_none

        // each source alone
        for (int i = 0; i < NPORTS; i++) begin
            run_source(i, 1);
            wait_frames(i + 1);
        end

        // three phases with all sources pending
        for (int phase = 0; phase < 3; phase++) begin
            pay_bp = (phase == 1);
            hdr_bp = (phase == 2);
            fork
                run_source(0, ROUNDS);
                run_source(1, ROUNDS);
                run_source(2, ROUNDS);
                run_source(3, ROUNDS);
            join
            wait_frames(NPORTS + (phase + 1) * ROUNDS * NPORTS);
        end
        hdr_bp = 1'b0;
        pay_bp = 1'b0;
        repeat (20) @(negedge clk);

        if (hdr_q.size() != 0 || beat_q.size() != 0) begin
            $display("Error at %0t: unexpected output left over", $time);
            errors++;
        end
        $display("frames %0d of %0d, errors %0d", frames_done, TOT_FRAMES, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(LIMIT_NS);
        $display("run timed out after %0d ns with %0d frames received", LIMIT_NS,
                 frames_done);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- dv/ip_arb_mux_chk.sv
`timescale 1ns/1ns

module ip_arb_mux_chk import ip_arb_mux_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       m_hdr_valid,
    input logic       m_hdr_ready,
    input ip_hdr_t    m_hdr,
    input logic       m_pay_valid,
    input logic       m_pay_ready,
    input ip_beat_t   m_pay,
    input port_mask_t s_hdr_ready,
    input port_mask_t s_pay_ready,
    input logic       grant_valid
);

    // stalled header stays put
    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        (m_hdr_valid && !m_hdr_ready) |=> (m_hdr_valid && $stable(m_hdr)))
        else $error("header changed while stalled");

    pay_hold: assert property (@(posedge clk) disable iff (rst)
        (m_pay_valid && !m_pay_ready) |=> (m_pay_valid && $stable(m_pay)))
        else $error("payload changed while stalled");

    hdr_ready_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(s_hdr_ready))
        else $error("more than one header ready bit high");

    // payload only flows under a grant
    pay_ready_granted: assert property (@(posedge clk) disable iff (rst)
        (!grant_valid) |-> (s_pay_ready == '0))
        else $error("payload ready without a grant");

endmodule

bind ip_arb_mux ip_arb_mux_chk chk_i (
    .clk(clk),
    .rst(rst),
    .m_hdr_valid(m_hdr_valid),
    .m_hdr_ready(m_hdr_ready),
    .m_hdr(m_hdr),
    .m_pay_valid(m_pay_valid),
    .m_pay_ready(m_pay_ready),
    .m_pay(m_pay),
    .s_hdr_ready(s_hdr_ready),
    .s_pay_ready(s_pay_ready),
    .grant_valid(grant_valid)
);

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- hw/ip_arb_mux.sv
`timescale 1ns/1ns

`include "ip_arb_mux_settings.svh"

module ip_arb_mux import ip_arb_mux_pkg::*; (
    input  logic                         clk,
    input  logic                         rst,

    // frame sources
    input  port_mask_t                   s_hdr_valid,
    output port_mask_t                   s_hdr_ready,
    input  ip_hdr_t [`IP_ARB_PORTS-1:0]  s_hdr,
    input  port_mask_t                   s_pay_valid,
    output port_mask_t                   s_pay_ready,
    input  ip_beat_t [`IP_ARB_PORTS-1:0] s_pay,

    // merged output
    output logic                         m_hdr_valid,
    input  logic                         m_hdr_ready,
    output ip_hdr_t                      m_hdr,
    output logic                         m_pay_valid,
    input  logic                         m_pay_ready,
    output ip_beat_t                     m_pay
);

    port_mask_t request;
    port_mask_t acknowledge;
    port_mask_t grant;
    logic       grant_valid;
    port_idx_t  grant_idx;

    logic       sel_valid;
    ip_beat_t   sel_beat;
    logic       ready_int;

    rr_arbiter #(
        .PORTS(`IP_ARB_PORTS)
    ) arb_i (
        .clk(clk),
        .rst(rst),
        .request(request),
        .acknowledge(acknowledge),
        .grant(grant),
        .grant_valid(grant_valid),
        .grant_idx(grant_idx)
    );

    ip_frame_ctrl frame_i (
        .clk(clk),
        .rst(rst),
        .s_hdr_valid(s_hdr_valid),
        .s_hdr_ready(s_hdr_ready),
        .s_hdr(s_hdr),
        .s_pay_valid(s_pay_valid),
        .s_pay_ready(s_pay_ready),
        .s_pay(s_pay),
        .request(request),
        .acknowledge(acknowledge),
        .grant(grant),
        .grant_valid(grant_valid),
        .grant_idx(grant_idx),
        .m_hdr_valid(m_hdr_valid),
        .m_hdr_ready(m_hdr_ready),
        .m_hdr(m_hdr),
        .sel_valid(sel_valid),
        .sel_beat(sel_beat),
        .ready_int(ready_int)
    );

    ip_payload_skid skid_i (
        .clk(clk),
        .rst(rst),
        .in_valid(sel_valid),
        .in_beat(sel_beat),
        .ready_int(ready_int),
        .out_valid(m_pay_valid),
        .out_ready(m_pay_ready),
        .out_beat(m_pay)
    );

endmodule

//--- hw/ip_payload_skid.sv
`timescale 1ns/1ns

module ip_payload_skid import ip_arb_mux_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    input  ip_beat_t in_beat,
    output logic     ready_int,

    output logic     out_valid,
    input  logic     out_ready,
    output ip_beat_t out_beat
);

    logic     temp_valid;
    ip_beat_t temp_beat;

    logic     out_valid_next;
    logic     temp_valid_next;
    logic     ready_early;

    logic     load_out;
    logic     load_temp;
    logic     temp_to_out;

    // stay ready unless the temp register could fill on the next edge
    assign ready_early = out_ready || (!temp_valid && (!out_valid || !in_valid));

    always_comb begin
        out_valid_next  = out_valid;
        temp_valid_next = temp_valid;
        load_out        = 1'b0;
        load_temp       = 1'b0;
        temp_to_out     = 1'b0;

        if (ready_int) begin
            if (out_ready || !out_valid) begin
                // output free, straight through
                out_valid_next = in_valid;
                load_out       = 1'b1;
            end else begin
                // output stalled, park the beat
                temp_valid_next = in_valid;
                load_temp       = 1'b1;
            end
        end else if (out_ready) begin
            // drain the parked beat first
            out_valid_next  = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            ready_int  <= 1'b0;
        end else begin
            out_valid  <= out_valid_next;
            temp_valid <= temp_valid_next;
            ready_int  <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_beat <= in_beat;
        end else if (temp_to_out) begin
            out_beat <= temp_beat;
        end

        if (load_temp) begin
            temp_beat <= in_beat;
        end
    end

endmodule

//--- hw/ip_frame_ctrl.sv
`timescale 1ns/1ns

`include "ip_arb_mux_settings.svh"

module ip_frame_ctrl import ip_arb_mux_pkg::*; (
    input  logic                           clk,
    input  logic                           rst,

    // source side
    input  port_mask_t                     s_hdr_valid,
    output port_mask_t                     s_hdr_ready,
    input  ip_hdr_t [`IP_ARB_PORTS-1:0]    s_hdr,
    input  port_mask_t                     s_pay_valid,
    output port_mask_t                     s_pay_ready,
    input  ip_beat_t [`IP_ARB_PORTS-1:0]   s_pay,

    // arbiter
    output port_mask_t                     request,
    output port_mask_t                     acknowledge,
    input  port_mask_t                     grant,
    input  logic                           grant_valid,
    input  port_idx_t                      grant_idx,

    // header output
    output logic                           m_hdr_valid,
    input  logic                           m_hdr_ready,
    output ip_hdr_t                        m_hdr,

    // payload towards the skid buffer
    output logic                           sel_valid,
    output ip_beat_t                       sel_beat,
    input  logic                           ready_int
);

    logic frame_reg;
    logic frame_start;
    logic pay_open;
    logic last_xfer;

    // open a frame once the header register is free or draining
    assign frame_start = !frame_reg && grant_valid && (m_hdr_ready || !m_hdr_valid);

    // payload only flows for the granted source after its header was taken
    assign pay_open = ready_int && grant_valid && frame_reg;

    assign s_pay_ready = pay_open ? (port_mask_t'(1) << grant_idx) : '0;

    assign sel_valid = s_pay_valid[grant_idx] && pay_open;
    assign sel_beat  = s_pay[grant_idx];

    assign last_xfer = sel_valid && sel_beat.last;

    // a granted source stops requesting
    assign request = s_hdr_valid & ~grant;

    // release on the last beat of the granted source
    assign acknowledge = last_xfer ? grant : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            frame_reg   <= 1'b0;
            s_hdr_ready <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            // one cycle pulse at the granted bit
            s_hdr_ready <= frame_start ? grant : '0;

            if (frame_start) begin
                frame_reg   <= 1'b1;
                m_hdr_valid <= 1'b1;
            end else begin
                if (m_hdr_ready) begin
                    m_hdr_valid <= 1'b0;
                end
                if (last_xfer) begin
                    frame_reg <= 1'b0;
                end
            end
        end
    end

    // header payload register
    always_ff @(posedge clk) begin
        if (frame_start) begin
            m_hdr <= s_hdr[grant_idx];
        end
    end

endmodule

//--- hw/rr_arbiter.sv
`timescale 1ns/1ns

`include "ip_arb_mux_settings.svh"

module rr_arbiter import ip_arb_mux_pkg::*; #(
    parameter int PORTS = `IP_ARB_PORTS
) (
    input  logic       clk,
    input  logic       rst,
    input  port_mask_t request,
    input  port_mask_t acknowledge,
    output port_mask_t grant,
    output logic       grant_valid,
    output port_idx_t  grant_idx
);

    port_mask_t mask_reg;
    port_mask_t masked_req;
    port_idx_t  pick_idx;

    // lowest set bit wins
    function automatic port_idx_t first_set(input port_mask_t bits);
        port_idx_t idx;
        idx = '0;
        for (int i = PORTS - 1; i >= 0; i--) begin
            if (bits[i]) begin
                idx = port_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // sources numbered above the one just granted
    function automatic port_mask_t upper_mask(input port_idx_t idx);
        port_mask_t m;
        m = '0;
        for (int i = 0; i < PORTS; i++) begin
            m[i] = (i > int'(idx));
        end
        return m;
    endfunction

    assign masked_req = request & mask_reg;

    // wrap around to the lowest requester once the upper ones are exhausted
    always_comb begin
        if (|masked_req) begin
            pick_idx = first_set(masked_req);
        end else begin
            pick_idx = first_set(request);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant       <= '0;
            grant_valid <= 1'b0;
            grant_idx   <= '0;
            mask_reg    <= '1;
        end else if (grant_valid) begin
            // held until the owner acknowledges
            if (|(grant & acknowledge)) begin
                grant       <= '0;
                grant_valid <= 1'b0;
            end
        end else if (|request) begin
            grant       <= port_mask_t'(1) << pick_idx;
            grant_valid <= 1'b1;
            grant_idx   <= pick_idx;
            mask_reg    <= upper_mask(pick_idx);
        end
    end

endmodule

//--- hw/ip_arb_mux_pkg.sv
`include "ip_arb_mux_settings.svh"

package ip_arb_mux_pkg;

    // encoded source number
    typedef logic [$clog2(`IP_ARB_PORTS)-1:0] port_idx_t;

    // one bit per source
    typedef logic [`IP_ARB_PORTS-1:0] port_mask_t;

    // ethernet and ipv4 header, first field in the msbs
    typedef struct packed {
        logic [`IP_MAC_WIDTH-1:0]  eth_dest_mac;
        logic [`IP_MAC_WIDTH-1:0]  eth_src_mac;
        logic [15:0]               eth_type;
        logic [3:0]                version;
        logic [3:0]                ihl;
        logic [5:0]                dscp;
        logic [1:0]                ecn;
        logic [15:0]               length;
        logic [15:0]               identification;
        logic [2:0]                flags;
        logic [12:0]               fragment_offset;
        logic [7:0]                ttl;
        logic [7:0]                protocol;
        logic [15:0]               header_checksum;
        logic [`IP_ADDR_WIDTH-1:0] source_ip;
        logic [`IP_ADDR_WIDTH-1:0] dest_ip;
    } ip_hdr_t;

    // one payload transfer
    typedef struct packed {
        logic [`IP_DATA_WIDTH-1:0] data;
        logic                      last;
        logic [`IP_USER_WIDTH-1:0] user;
    } ip_beat_t;

endpackage

//--- include/ip_arb_mux_settings.svh
`ifndef IP_ARB_MUX_SETTINGS_SVH
`define IP_ARB_MUX_SETTINGS_SVH

// number of frame sources sharing the output
`define IP_ARB_PORTS 4

// payload beat fields
`define IP_DATA_WIDTH 8
`define IP_USER_WIDTH 1

// ethernet hardware address
`define IP_MAC_WIDTH 48

// ipv4 address
`define IP_ADDR_WIDTH 32

`endif
